//--- src/memPkg.sv
package memPkg;

    // byte address seen by the core, only the low bits reach the RAM
    typedef logic [31:0] addr_t;

    // one RAM data byte
    typedef logic [7:0] byte_t;

    // access length in bytes
    typedef logic [2:0] memLen_t;

    localparam memLen_t lenByte = 3'd1;
    localparam memLen_t lenHalf = 3'd2;
    localparam memLen_t lenWord = 3'd4;

    // RAM geometry
    localparam int ramDepth = 256;
    localparam int ramAddrBits = 8;

endpackage

//--- src/corePkg.sv
package corePkg;

    // instruction or data word
    typedef logic [31:0] word_t;

    // data-side request, held until dataDone
    typedef struct packed {
        logic            write;
        memPkg::memLen_t len;
        memPkg::addr_t   addr;
        // little-endian, byte 0 goes to addr
        word_t           wdata;
    } dataReq_t;

    // first fetch address after reset
    localparam memPkg::addr_t resetPc = 32'h0000_0000;

endpackage

//--- src/byteRam.sv
`timescale 1ns/1ps

module byteRam (
    input  logic          clk,
    input  memPkg::addr_t ramAddr,
    input  logic          ramWe,
    input  memPkg::byte_t ramWdata,
    output memPkg::byte_t ramRdata
);
    import memPkg::*;

    byte_t mem [ramDepth];
    logic [ramAddrBits-1:0] idx;

    assign idx = ramAddr[ramAddrBits-1:0];

    initial begin
        $readmemh("memInit.hex", mem);
    end

    // read data is registered, a read during a write sees the old byte
    always_ff @(posedge clk) begin
        if (ramWe) begin
            mem[idx] <= ramWdata;
        end
        ramRdata <= mem[idx];
    end

endmodule

//--- src/memCtrl.sv
`timescale 1ns/1ps

module memCtrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              ioBufferFull,
    input  logic              fetchEn,
    input  memPkg::addr_t     fetchAddr,
    input  logic              dataEn,
    input  corePkg::dataReq_t dataReq,
    input  memPkg::byte_t     ramRdata,
    output logic              instDone,
    output corePkg::word_t    instWord,
    output logic              dataDone,
    output corePkg::word_t    dataRdata,
    output memPkg::addr_t     ramAddr,
    output logic              ramWe,
    output memPkg::byte_t     ramWdata
);
    import memPkg::*;
    import corePkg::*;

    typedef enum logic [1:0] {
        kindIdle,
        kindRdInst,
        kindRdData,
        kindWrData
    } reqKind_t;

    reqKind_t kind;
    logic [2:0] stage;

    // latched request
    addr_t   addrReg;
    memLen_t lenReg;
    word_t   dataReg;

    logic       frozen;
    logic       reading;
    logic       lastRead;
    logic       lastWrite;
    logic [1:0] capIdx;
    logic [2:0] addrOffset;
    word_t      readWord;

    assign frozen = !rdy || ioBufferFull;
    assign reading = (kind == kindRdInst) || (kind == kindRdData);

    // read ends one stage after its last address, write ends on its last byte
    assign lastRead = reading && (stage == lenReg);
    assign lastWrite = (kind == kindWrData) && (stage == lenReg - 3'd1);

    // byte captured in this stage was addressed one stage earlier
    assign capIdx = stage[1:0] - 2'd1;

    // While frozen, present the previous byte address again. The RAM then
    // keeps returning the byte that is due for capture once the freeze ends.
    always_comb begin
        if (reading && frozen && (stage != 3'd0)) begin
            addrOffset = stage - 3'd1;
        end else begin
            addrOffset = stage;
        end
    end

    assign ramAddr = addrReg + addr_t'(addrOffset);
    assign ramWe = !frozen && (kind == kindWrData);
    assign ramWdata = dataReg[{stage[1:0], 3'b000} +: 8];

    // last byte goes straight from the RAM, upper bytes stay zero
    assign readWord = dataReg | (word_t'(ramRdata) << {lenReg[1:0] - 2'd1, 3'b000});

    assign instWord = readWord;
    assign dataRdata = readWord;

    assign instDone = !frozen && lastRead && (kind == kindRdInst);
    assign dataDone = !frozen && ((lastRead && (kind == kindRdData)) || lastWrite);

    // request kind and stage
    always_ff @(posedge clk) begin
        if (rst) begin
            kind <= kindIdle;
            stage <= 3'd0;
        end else if (!frozen) begin
            if (kind == kindIdle) begin
                stage <= 3'd0;
                // data side wins over fetch
                if (dataEn) begin
                    kind <= dataReq.write ? kindWrData : kindRdData;
                end else if (fetchEn) begin
                    kind <= kindRdInst;
                end
            end else if (lastRead || lastWrite) begin
                kind <= kindIdle;
                stage <= 3'd0;
            end else begin
                stage <= stage + 3'd1;
            end
        end
    end

    // address, length and data bytes
    always_ff @(posedge clk) begin
        if (!frozen) begin
            if (kind == kindIdle) begin
                if (dataEn) begin
                    addrReg <= dataReq.addr;
                    lenReg <= dataReq.len;
                    dataReg <= dataReq.write ? dataReq.wdata : '0;
                end else begin
                    addrReg <= fetchAddr;
                    lenReg <= lenWord;
                    dataReg <= '0;
                end
            end else if (reading && (stage != 3'd0) && !lastRead) begin
                dataReg[{capIdx, 3'b000} +: 8] <= ramRdata;
            end
        end
    end

endmodule

//--- src/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
    input  logic           clk,
    input  logic           rst,
    input  logic           instDone,
    input  corePkg::word_t instWord,
    input  logic           redirect,
    input  memPkg::addr_t  redirectPc,
    output logic           fetchEn,
    output memPkg::addr_t  fetchAddr,
    output logic           instValid,
    output corePkg::word_t instOut,
    output memPkg::addr_t  instPc
);
    import memPkg::*;
    import corePkg::*;

    addr_t pc;
    logic  running;

    // next instDone belongs to a fetch from before the redirect
    logic  squash;

    assign fetchEn = running;
    assign fetchAddr = pc;

    assign instValid = instDone && !squash && !redirect;
    assign instOut = instWord;
    assign instPc = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
            running <= 1'b0;
            squash <= 1'b0;
        end else begin
            running <= 1'b1;
            if (redirect) begin
                pc <= redirectPc;
                // a fetch finishing now needs no squash
                squash <= !instDone;
            end else if (instDone) begin
                if (!squash) begin
                    pc <= pc + 32'd4;
                end
                squash <= 1'b0;
            end
        end
    end

endmodule

//--- src/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              ioBufferFull,
    input  logic              redirect,
    input  memPkg::addr_t     redirectPc,
    input  logic              dataEn,
    input  corePkg::dataReq_t dataReq,
    output logic              dataDone,
    output corePkg::word_t    dataRdata,
    output logic              instValid,
    output corePkg::word_t    instOut,
    output memPkg::addr_t     instPc
);
    import memPkg::*;
    import corePkg::*;

    // fetch side
    logic  fetchEn;
    addr_t fetchAddr;
    logic  instDone;
    word_t instWord;

    // RAM port
    addr_t ramAddr;
    logic  ramWe;
    byte_t ramWdata;
    byte_t ramRdata;

    fetchUnit fetch (
        .clk        (clk),
        .rst        (rst),
        .instDone   (instDone),
        .instWord   (instWord),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr),
        .instValid  (instValid),
        .instOut    (instOut),
        .instPc     (instPc)
    );

    memCtrl ctrl (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .dataEn       (dataEn),
        .dataReq      (dataReq),
        .ramRdata     (ramRdata),
        .instDone     (instDone),
        .instWord     (instWord),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .ramAddr      (ramAddr),
        .ramWe        (ramWe),
        .ramWdata     (ramWdata)
    );

    byteRam ram (
        .clk      (clk),
        .ramAddr  (ramAddr),
        .ramWe    (ramWe),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

endmodule

//--- testbench/memCtrl_assertions.sv
`timescale 1ns/1ps

module memCtrlAssertions (
    input logic clk,
    input logic rst,
    input logic rdy,
    input logic ioBufferFull,
    input logic dataEn,
    input logic ramWe,
    input logic instDone,
    input logic dataDone
);

    property oneDoneAtATime;
        @(posedge clk) disable iff (rst) !(instDone && dataDone);
    endproperty

    // nothing moves while frozen
    property quietWhenFrozen;
        @(posedge clk) disable iff (rst)
            (!rdy || ioBufferFull) |-> !(ramWe || instDone || dataDone);
    endproperty

    property dataDoneNeedsRequest;
        @(posedge clk) disable iff (rst) dataDone |-> dataEn;
    endproperty

    assert property (oneDoneAtATime)
        else $error("instDone and dataDone are high in the same cycle");
    assert property (quietWhenFrozen)
        else $error("ramWe or a done pulse is high while the controller is frozen");
    assert property (dataDoneNeedsRequest)
        else $error("dataDone is high without dataEn");

endmodule

bind memCtrl memCtrlAssertions memCtrlChecks (
    .clk          (clk),
    .rst          (rst),
    .rdy          (rdy),
    .ioBufferFull (ioBufferFull),
    .dataEn       (dataEn),
    .ramWe        (ramWe),
    .instDone     (instDone),
    .dataDone     (dataDone)
);

//--- testbench/memSubsystemTb.sv
`timescale 1ns/1ps

module memSubsystemTb;
    import memPkg::*;
    import corePkg::*;

    // worst-case cycles per test, used for the watchdog
    localparam int seqFetchCycles = 120;
    localparam int loadCycles = 180;
    localparam int storeCycles = 160;
    localparam int priorityCycles = 340;
    localparam int freezeCycles = 140;
    localparam int redirectCycles = 200;
    localparam int marginCycles = 200;
    localparam int timeoutCycles = seqFetchCycles + loadCycles + storeCycles
        + priorityCycles + freezeCycles + redirectCycles + marginCycles;

    logic     clk;
    logic     rst;
    logic     rdy;
    logic     ioBufferFull;
    logic     redirect;
    addr_t    redirectPc;
    logic     dataEn;
    dataReq_t dataReq;
    logic     dataDone;
    word_t    dataRdata;
    logic     instValid;
    word_t    instOut;
    addr_t    instPc;

    // reference copy of the RAM
    byte_t model [ramDepth];

    logic [31:0] rngState;
    addr_t       expPc;
    string       testName;
    int          errors;
    int          checks;
    int          startErrors;
    int          testsRun;
    int          cycleCount;

    // data request waiting for its dataDone
    logic     pendValid;
    dataReq_t pendReq;

    memSubsystem DUT (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .dataEn       (dataEn),
        .dataReq      (dataReq),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .instValid    (instValid),
        .instOut      (instOut),
        .instPc       (instPc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function automatic memLen_t pickLen(input logic [31:0] r);
        case (r[1:0])
            2'd0: return lenByte;
            2'd1: return lenHalf;
            default: return lenWord;
        endcase
    endfunction

    // little-endian, zero-extended word of len bytes at addr
    function automatic word_t refWord(input addr_t addr, input memLen_t len);
        word_t w;
        addr_t a;
        int k;
        w = '0;
        for (k = 0; k < int'(len); k++) begin
            a = addr + addr_t'(k);
            w = w | (word_t'(model[a[ramAddrBits-1:0]]) << (8 * k));
        end
        return w;
    endfunction

    task automatic modelStore(input dataReq_t r);
        addr_t a;
        int k;
        for (k = 0; k < int'(r.len); k++) begin
            a = r.addr + addr_t'(k);
            model[a[ramAddrBits-1:0]] = r.wdata[8*k +: 8];
        end
    endtask

    task automatic reportMismatch(input string what, input word_t exp, input word_t act);
        errors++;
        $display("error %s (%s): expected %h, actual %h", testName, what, exp, act);
    endtask

    task automatic reportFault(input string msg);
        errors++;
        $display("%s, during test %s", msg, testName);
    endtask

    // compares every completed fetch and data access with the model
    always @(negedge clk) begin
        word_t expWord;
        if (!rst) begin
            if (redirect) begin
                expPc = redirectPc;
            end
            assert (!((!rdy || ioBufferFull) && (instValid || dataDone)))
                else reportFault("a done pulse appeared while the controller was frozen");
            if (instValid) begin
                checks++;
                assert (instPc == expPc) else reportMismatch("instPc", expPc, instPc);
                expWord = refWord(expPc, lenWord);
                assert (instOut == expWord) else reportMismatch("instOut", expWord, instOut);
                expPc = expPc + 32'd4;
            end
            if (dataDone) begin
                assert (pendValid) else reportFault("dataDone came with no request pending");
                if (pendValid && pendReq.write) begin
                    modelStore(pendReq);
                end else if (pendValid) begin
                    checks++;
                    expWord = refWord(pendReq.addr, pendReq.len);
                    assert (dataRdata == expWord)
                        else reportMismatch("dataRdata", expWord, dataRdata);
                end
                pendValid = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout, the run went past %0d cycles", timeoutCycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic waitInstValid();
        @(negedge clk);
        while (!instValid) begin
            @(negedge clk);
        end
    endtask

    // must start in the cycle after a done pulse, so the controller is idle
    task automatic dataAccess(input logic write, input memLen_t len, input addr_t addr,
                              input word_t wdata, input int freezeAt, input int freezeLen,
                              input logic useIoFull);
        int cycles;
        int expCycles;
        logic frz;
        @(posedge clk);
        #2;
        dataEn = 1'b1;
        dataReq.write = write;
        dataReq.len = len;
        dataReq.addr = addr;
        dataReq.wdata = wdata;
        pendReq = dataReq;
        pendValid = 1'b1;
        expCycles = (write ? int'(len) : int'(len) + 1) + freezeLen;
        cycles = 0;
        @(negedge clk);
        while (!dataDone) begin
            cycles++;
            @(posedge clk);
            #2;
            frz = (freezeLen > 0) && (cycles >= freezeAt) && (cycles < freezeAt + freezeLen);
            rdy = !(frz && !useIoFull);
            ioBufferFull = frz && useIoFull;
            @(negedge clk);
        end
        checks++;
        assert (cycles == expCycles)
            else reportMismatch("latency", word_t'(expCycles), word_t'(cycles));
    endtask

    task automatic releaseData();
        @(posedge clk);
        #2;
        dataEn = 1'b0;
    endtask

    task automatic freezeFor(input logic useIoFull, input int n);
        repeat (3) @(posedge clk);
        #2;
        rdy = useIoFull;
        ioBufferFull = useIoFull;
        repeat (n) @(posedge clk);
        #2;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
    endtask

    // strobe lands while the next fetch is outstanding
    task automatic redirectTo(input addr_t target);
        waitInstValid();
        repeat (2) @(posedge clk);
        #2;
        redirect = 1'b1;
        redirectPc = target;
        @(posedge clk);
        #2;
        redirect = 1'b0;
    endtask

    task automatic startTest(input string name);
        testName = name;
        startErrors = errors;
    endtask

    task automatic finishTest();
        testsRun++;
        $display("test %s done, %0d errors", testName, errors - startErrors);
    endtask

    initial begin
        addr_t a;
        addr_t target;
        memLen_t len;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        dataEn = 1'b0;
        dataReq = '0;
        pendValid = 1'b0;
        pendReq = '0;
        rngState = 32'h63fd;
        expPc = resetPc;
        errors = 0;
        checks = 0;
        testsRun = 0;
        cycleCount = 0;
        testName = "reset";
        $readmemh("memInit.hex", model);
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        startTest("sequential fetch");
        repeat (16) waitInstValid();
        finishTest();

        startTest("loads");
        waitInstValid();
        repeat (24) begin
            len = pickLen(nextRand());
            a = nextRand() & 32'hff;
            dataAccess(1'b0, len, a, '0, 0, 0, 1'b0);
        end
        releaseData();
        finishTest();

        startTest("stores");
        waitInstValid();
        for (int i = 0; i < 12; i++) begin
            len = pickLen(32'(i));
            a = nextRand() & 32'hff;
            if (len == lenHalf) a = {a[31:1], 1'b0};
            if (len == lenWord) a = {a[31:2], 2'b00};
            dataAccess(1'b1, len, a, nextRand(), 0, 0, 1'b0);
            dataAccess(1'b0, lenWord, {a[31:2], 2'b00}, '0, 0, 0, 1'b0);
        end
        releaseData();
        finishTest();

        startTest("priority");
        repeat (4) begin
            waitInstValid();
            repeat (5) begin
                len = pickLen(nextRand());
                a = nextRand() & 32'hff;
                dataAccess(rngState[8], len, a, nextRand(), 0, 0, 1'b0);
            end
            releaseData();
            repeat (6) waitInstValid();
        end
        finishTest();

        startTest("freeze");
        waitInstValid();
        for (int i = 0; i < 6; i++) begin
            a = nextRand() & 32'hfc;
            dataAccess(i[0], lenWord, a, nextRand(), 2, 1 + (i % 3), i >= 3);
        end
        releaseData();
        waitInstValid();
        freezeFor(1'b0, 3);
        waitInstValid();
        freezeFor(1'b1, 4);
        repeat (4) waitInstValid();
        finishTest();

        startTest("redirect");
        repeat (4) begin
            target = nextRand() & 32'hfc;
            redirectTo(target);
            waitInstValid();
            checks++;
            assert (instPc == target) else reportMismatch("redirect target", target, instPc);
            repeat (3) waitInstValid();
        end
        finishTest();

        $display("tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- memInit.hex
// one byte per column, 16 bytes per line, first line holds addresses 0x00 to 0x0f
13 30 4d 6a 87 a4 c1 de fb 18 35 52 6f 8c a9 c6
e3 00 1d 3a 57 74 91 ae cb e8 05 22 3f 5c 79 96
b3 d0 ed 0a 27 44 61 7e 9b b8 d5 f2 0f 2c 49 66
83 a0 bd da f7 14 31 4e 6b 88 a5 c2 df fc 19 36
53 70 8d aa c7 e4 01 1e 3b 58 75 92 af cc e9 06
23 40 5d 7a 97 b4 d1 ee 0b 28 45 62 7f 9c b9 d6
f3 10 2d 4a 67 84 a1 be db f8 15 32 4f 6c 89 a6
c3 e0 fd 1a 37 54 71 8e ab c8 e5 02 1f 3c 59 76
93 b0 cd ea 07 24 41 5e 7b 98 b5 d2 ef 0c 29 46
63 80 9d ba d7 f4 11 2e 4b 68 85 a2 bf dc f9 16
33 50 6d 8a a7 c4 e1 fe 1b 38 55 72 8f ac c9 e6
03 20 3d 5a 77 94 b1 ce eb 08 25 42 5f 7c 99 b6
d3 f0 0d 2a 47 64 81 9e bb d8 f5 12 2f 4c 69 86
a3 c0 dd fa 17 34 51 6e 8b a8 c5 e2 ff 1c 39 56
73 90 ad ca e7 04 21 3e 5b 78 95 b2 cf ec 09 26
43 60 7d 9a b7 d4 f1 0e 2b 48 65 82 9f bc d9 f6

//--- memSubsystem.f
src/memPkg.sv
src/corePkg.sv
src/byteRam.sv
src/memCtrl.sv
src/fetchUnit.sv
src/memSubsystem.sv
testbench/memCtrl_assertions.sv
testbench/memSubsystemTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the memSubsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f memSubsystem.f \
    --top-module memSubsystemTb -Mdir obj_dir

out=$(./obj_dir/VmemSubsystemTb)
echo "$out"

if echo "$out" | grep -q "^sim passed$"; then
    exit 0
else
    exit 1
fi
